// File: compile.f
source/display_pkg.sv
source/screen_pos_if.sv
source/pixel_lookahead.sv
source/logo_layer.sv
source/glyph_font.sv
source/text_layer.sv
source/start_screen_pixel_driver.sv
verif/start_screen_tb.sv

// File: Bender.yml
package:
  name: start_screen

sources:
  - files:
      - source/display_pkg.sv
      - source/screen_pos_if.sv
      - source/pixel_lookahead.sv
      - source/logo_layer.sv
      - source/glyph_font.sv
      - source/text_layer.sv
      - source/start_screen_pixel_driver.sv
  - target: test
    files:
      - verif/start_screen_tb.sv

// File: source/logo_pixels.hex
// Tile colours RRGGBB, one line per tile row, tile columns 0 to 7 left to right
118800 129801 13a802 14b803 15c804 16d805 17e806 18f807
218908 229909 23a90a 24b90b 25c90c 26d90d 27e90e 28f90f
318a10 329a11 33aa12 34ba13 35ca14 36da15 37ea16 38fa17
418b18 429b19 43ab1a 44bb1b 45cb1c 46db1d 47eb1e 48fb1f
518c20 529c21 53ac22 54bc23 55cc24 56dc25 57ec26 58fc27
618d28 629d29 63ad2a 64bd2b 65cd2c 66dd2d 67ed2e 68fd2f
718e30 729e31 73ae32 74be33 75ce34 76de35 77ee36 78fe37
818f38 829f39 83af3a 84bf3b 85cf3c 86df3d 87ef3e 88ff3f

// File: verif/start_screen_golden.txt
# row col check expected_rgb, all in hex
# check 0 marks the first pixel of a raster run, which is driven but not compared
# Background after reset, away from every layer
1f4 063 0 000000
1f4 064 1 000000
1f4 065 1 000000
# Line 1 FRAME, glyph row 5 across the F to R boundary
019 00c 0 000000
019 00d 1 000000
019 00e 1 ffffff
019 00f 1 ffffff
019 010 1 000000
019 011 1 000000
019 012 1 000000
019 013 1 000000
019 014 1 ffffff
019 015 1 ffffff
019 016 1 000000
019 017 1 000000
# Logo left edge, tiles 0 and 1
19c 210 0 000000
19c 211 1 000000
19c 212 1 118800
19c 213 1 118800
19c 214 1 118800
19c 215 1 118800
19c 216 1 118800
19c 217 1 118800
19c 218 1 118800
19c 219 1 118800
19c 21a 1 129801
19c 21b 1 129801
# Logo bottom tile row and right edge
1db 24a 0 88ff3f
1db 24b 1 88ff3f
1db 24c 1 88ff3f
1db 24d 1 88ff3f
1db 24e 1 88ff3f
1db 24f 1 88ff3f
1db 250 1 88ff3f
1db 251 1 88ff3f
1db 252 1 000000
1db 253 1 000000
1db 254 1 000000
1db 255 1 000000
# Frame wrap into the A of line 0
257 31d 0 000000
257 31e 1 000000
257 31f 1 000000
000 000 1 000000
000 001 1 000000
000 002 1 ffffff
000 003 1 ffffff
000 004 1 ffffff

// File: verif/start_screen_tb.sv
`timescale 1ns/100ps

module start_screen_tb;

    localparam int    CLK_PERIOD   = 10;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    RESET_CYCLES = 4;
    localparam int    WATCHDOG_PAD = 20;
    localparam string GOLDEN_FILE  = "verif/start_screen_golden.txt";

    logic                      clk;
    logic                      reset;
    display_pkg::pixel_coord_t vga_row;
    display_pkg::pixel_coord_t vga_col;
    display_pkg::color_t       output_color;

    display_pkg::pixel_coord_t row_q[$];
    display_pkg::pixel_coord_t col_q[$];
    logic                      flag_q[$];
    display_pkg::color_t       expected_q[$];
    int                        line_q[$];  // File line for messages

    int   error_count;
    int   check_count;
    logic vectors_loaded;

    start_screen_pixel_driver i_dut (
        .clk          (clk),
        .reset        (reset),
        .vga_row      (vga_row),
        .vga_col      (vga_col),
        .output_color (output_color)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_color(input string               name,
                                 input display_pkg::color_t expected,
                                 input display_pkg::color_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s expected %06h actual %06h", name, expected, actual);
        end
    endtask

    task automatic read_golden_file();
        int                        fd;
        int                        line_no;
        int                        fields;
        string                     text;
        display_pkg::pixel_coord_t row;
        display_pkg::pixel_coord_t col;
        logic                      flag;
        display_pkg::color_t       expected;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) == 0) begin
                break;
            end
            line_no++;
            if (text.len() == 0 || text[0] == "#" || text[0] == "\n" || text[0] == "\r") begin
                continue;  // Comment or blank
            end
            fields = $sscanf(text, "%h %h %h %h", row, col, flag, expected);
            if (fields != 4) begin
                error_count++;
                $display("Golden file line %0d is malformed and was skipped", line_no);
                continue;
            end
            row_q.push_back(row);
            col_q.push_back(col);
            flag_q.push_back(flag);
            expected_q.push_back(expected);
            line_q.push_back(line_no);
        end
        $fclose(fd);
    endtask

    // Watchdog sized from the number of golden pixels
    initial begin
        wait (vectors_loaded);
        #((row_q.size() + WATCHDOG_PAD) * CLK_PERIOD);
        $display("Watchdog expired before all golden pixels were driven");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        string name;
        clk            = 1'b0;
        reset          = 1'b1;
        vga_row        = '0;
        vga_col        = '0;
        error_count    = 0;
        check_count    = 0;
        vectors_loaded = 1'b0;

        read_golden_file();
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        for (int i = 0; i < row_q.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            vga_row = row_q[i];
            vga_col = col_q[i];
            #(CLK_PERIOD - DRIVE_DELAY - 1);  // Just before the next edge
            if (flag_q[i]) begin
                name = $sformatf("golden line %0d (row %0d col %0d)",
                                 line_q[i], row_q[i], col_q[i]);
                compare_color(name, expected_q[i], output_color);
            end
        end

        if (check_count == 0) begin
            error_count++;
            $display("No pixel was checked");
        end
        $display("Checked %0d pixels, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: source/start_screen_pixel_driver.sv
`timescale 1ns/100ps

module start_screen_pixel_driver (
    input  logic                      clk,
    input  logic                      reset,
    input  display_pkg::pixel_coord_t vga_row,
    input  display_pkg::pixel_coord_t vga_col,
    output display_pkg::color_t       output_color
);

    logic                logo_hit;
    display_pkg::color_t logo_color;
    logic                text_hit;

    screen_pos_if pos ();

    assign pos.row = vga_row;
    assign pos.col = vga_col;

    pixel_lookahead i_pixel_lookahead (
        .pos (pos.tracker)
    );

    logo_layer i_logo_layer (
        .clk        (clk),
        .reset      (reset),
        .pos        (pos.layer),
        .logo_hit   (logo_hit),
        .logo_color (logo_color)
    );

    text_layer i_text_layer (
        .pos      (pos.layer),
        .text_hit (text_hit)
    );

    // Logo over text over background
    always_comb begin
        if (logo_hit) begin
            output_color = logo_color;
        end else if (text_hit) begin
            output_color = display_pkg::TEXT_COLOR;
        end else begin
            output_color = display_pkg::BG_COLOR;
        end
    end

endmodule

// File: source/text_layer.sv
`timescale 1ns/100ps

module text_layer (
    screen_pos_if.layer pos,
    output logic        text_hit
);

    display_pkg::pixel_coord_t          line_idx;
    display_pkg::pixel_coord_t          row_off;
    display_pkg::pixel_coord_t          char_slot;
    display_pkg::pixel_coord_t          col_off;
    logic [display_pkg::LINE_CHARS * 8 - 1:0] line_text;
    display_pkg::char_code_t            char_code;
    logic [2:0]                         glyph_row;
    logic [2:0]                         glyph_col;
    logic                               in_glyph;
    display_pkg::glyph_bits_t           glyph_bits;

    always_comb begin
        line_idx  = display_pkg::pixel_coord_t'(pos.row / display_pkg::LINE_PITCH);
        row_off   = display_pkg::pixel_coord_t'(pos.row % display_pkg::LINE_PITCH);
        char_slot = display_pkg::pixel_coord_t'(pos.col / display_pkg::CHAR_PITCH);
        col_off   = display_pkg::pixel_coord_t'(pos.col % display_pkg::CHAR_PITCH);

        case (line_idx)
            10'd0:   line_text = "A        ";
            10'd1:   line_text = "FRAME    ";
            10'd2:   line_text = "PERFECT  ";
            10'd3:   line_text = "GAME     ";
            10'd4:   line_text = "ADVENTURE";
            default: line_text = "         ";  // Below the title
        endcase

        // First character sits in the top byte of the string
        char_code = " ";
        if (char_slot < display_pkg::LINE_CHARS) begin
            char_code = line_text[8 * (display_pkg::LINE_CHARS - 1 - char_slot) +: 8];
        end

        glyph_row = 3'(row_off / display_pkg::GLYPH_SCALE);
        glyph_col = 3'(col_off / display_pkg::GLYPH_SCALE);
        in_glyph  = (row_off < display_pkg::GLYPH_ROWS * display_pkg::GLYPH_SCALE) &&
                    (col_off < display_pkg::GLYPH_COLS * display_pkg::GLYPH_SCALE);
    end

    glyph_font i_glyph_font (
        .char_code (char_code),
        .glyph_row (glyph_row),
        .bits      (glyph_bits)
    );

    always_comb begin
        text_hit = 1'b0;
        if (in_glyph) begin
            text_hit = glyph_bits[display_pkg::GLYPH_COLS - 1 - glyph_col];
        end
    end

    always_comb begin
        if (!$isunknown(pos.row)) begin
            a_text_in_title: assert final (
                !(text_hit && (pos.row >= display_pkg::TEXT_LINES * display_pkg::LINE_PITCH)))
            else $error("text drawn below the title at row %0d", pos.row);
        end
    end

endmodule

// File: source/glyph_font.sv
`timescale 1ns/100ps

module glyph_font (
    input  display_pkg::char_code_t  char_code,
    input  logic [2:0]               glyph_row,
    output display_pkg::glyph_bits_t bits
);

    // Seven rows of five bits, top row in the MSBs
    logic [display_pkg::GLYPH_ROWS * display_pkg::GLYPH_COLS - 1:0] glyph;

    always_comb begin
        case (char_code)
            "A":     glyph = 35'b01110_10001_10001_11111_10001_10001_10001;
            "C":     glyph = 35'b01110_10001_10000_10000_10000_10001_01110;
            "D":     glyph = 35'b11110_10001_10001_10001_10001_10001_11110;
            "E":     glyph = 35'b11111_10000_10000_11110_10000_10000_11111;
            "F":     glyph = 35'b11111_10000_10000_11110_10000_10000_10000;
            "G":     glyph = 35'b01110_10001_10000_10111_10001_10001_01111;
            "M":     glyph = 35'b10001_11011_10101_10101_10001_10001_10001;
            "N":     glyph = 35'b10001_10001_11001_10101_10011_10001_10001;
            "P":     glyph = 35'b11110_10001_10001_11110_10000_10000_10000;
            "R":     glyph = 35'b11110_10001_10001_11110_10100_10010_10001;
            "T":     glyph = 35'b11111_00100_00100_00100_00100_00100_00100;
            "U":     glyph = 35'b10001_10001_10001_10001_10001_10001_01110;
            "V":     glyph = 35'b10001_10001_10001_10001_10001_01010_00100;
            default: glyph = '0;  // Space and unsupported codes
        endcase
    end

    always_comb begin
        bits = '0;
        if (glyph_row < display_pkg::GLYPH_ROWS) begin
            bits = glyph[(display_pkg::GLYPH_ROWS - 1 - glyph_row) * display_pkg::GLYPH_COLS
                         +: display_pkg::GLYPH_COLS];
        end
    end

endmodule

// File: source/logo_layer.sv
`timescale 1ns/100ps

module logo_layer (
    input  logic                clk,
    input  logic                reset,
    screen_pos_if.layer         pos,
    output logic                logo_hit,
    output display_pkg::color_t logo_color
);

    display_pkg::color_t       logo_rom [display_pkg::LOGO_WORDS];
    display_pkg::pixel_coord_t rel_row;
    display_pkg::pixel_coord_t rel_col;
    display_pkg::pixel_coord_t tile_index;  // Before truncation to the ROM width
    display_pkg::logo_addr_t   rom_addr;
    logic                      next_in_window;

    // Lower edges inclusive, upper edges exclusive
    function automatic logic in_window(input display_pkg::pixel_coord_t r,
                                       input display_pkg::pixel_coord_t c);
        int span;
        span = display_pkg::LOGO_TILES * display_pkg::LOGO_TILE_PX;
        return (r >= display_pkg::LOGO_ORIGIN_ROW) &&
               (r <  display_pkg::LOGO_ORIGIN_ROW + span) &&
               (c >= display_pkg::LOGO_ORIGIN_COL) &&
               (c <  display_pkg::LOGO_ORIGIN_COL + span);
    endfunction

    initial begin
        $readmemh("source/logo_pixels.hex", logo_rom);
    end

    // Address from the next pixel so the registered colour meets the current one
    always_comb begin
        rel_row = pos.row_next - display_pkg::pixel_coord_t'(display_pkg::LOGO_ORIGIN_ROW);
        rel_col = pos.col_next - display_pkg::pixel_coord_t'(display_pkg::LOGO_ORIGIN_COL);
        tile_index = display_pkg::pixel_coord_t'(
            (rel_row / display_pkg::LOGO_TILE_PX) * display_pkg::LOGO_TILES +
            (rel_col / display_pkg::LOGO_TILE_PX));
        rom_addr = display_pkg::logo_addr_t'(tile_index);
        next_in_window = in_window(pos.row_next, pos.col_next);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            logo_color <= display_pkg::BG_COLOR;
        end else begin
            logo_color <= logo_rom[rom_addr];
        end
    end

    assign logo_hit = in_window(pos.row, pos.col);

    a_tile_in_rom: assert property (
        @(posedge clk) disable iff (reset)
        next_in_window |-> (tile_index < display_pkg::LOGO_WORDS))
    else $error("logo tile index %0d beyond ROM", tile_index);

endmodule

// File: source/pixel_lookahead.sv
`timescale 1ns/100ps

module pixel_lookahead (
    screen_pos_if.tracker pos
);

    always_comb begin
        pos.row_next = pos.row;
        pos.col_next = pos.col + 10'd1;
        if (pos.col == display_pkg::pixel_coord_t'(display_pkg::SVGA_WIDTH - 1)) begin
            pos.col_next = '0;
            if (pos.row == display_pkg::pixel_coord_t'(display_pkg::SVGA_HEIGHT - 1)) begin
                pos.row_next = '0;  // End of frame
            end else begin
                pos.row_next = pos.row + 10'd1;
            end
        end
    end

    // Valid only while the scan itself stays on screen
    always_comb begin
        if (!$isunknown({pos.row, pos.col}) &&
            (pos.row < display_pkg::SVGA_HEIGHT) &&
            (pos.col < display_pkg::SVGA_WIDTH)) begin
            a_next_on_screen: assert final (
                (pos.row_next < display_pkg::SVGA_HEIGHT) &&
                (pos.col_next < display_pkg::SVGA_WIDTH))
            else $error("look-ahead left the screen at row %0d col %0d", pos.row, pos.col);
        end
    end

endmodule

// File: source/screen_pos_if.sv
`timescale 1ns/100ps

interface screen_pos_if;

    display_pkg::pixel_coord_t row;
    display_pkg::pixel_coord_t col;
    display_pkg::pixel_coord_t row_next;  // Raster successor of row/col
    display_pkg::pixel_coord_t col_next;

    modport tracker (
        input  row,
        input  col,
        output row_next,
        output col_next
    );

    modport layer (
        input row,
        input col,
        input row_next,
        input col_next
    );

endinterface

// File: source/display_pkg.sv
package display_pkg;

    typedef logic [9:0]  pixel_coord_t;  // Screen row or column
    typedef logic [23:0] color_t;        // 8 bits each of R, G, B
    typedef logic [7:0]  char_code_t;    // ASCII
    typedef logic [5:0]  logo_addr_t;    // One word per logo tile
    typedef logic [4:0]  glyph_bits_t;   // Column 0 in the MSB

    // SVGA frame
    localparam int SVGA_WIDTH  = 800;
    localparam int SVGA_HEIGHT = 600;

    localparam color_t BG_COLOR   = 24'h00_0000;
    localparam color_t TEXT_COLOR = 24'hff_ffff;

    // Logo window, 8x8 tiles of 8x8 pixels
    localparam int LOGO_ORIGIN_ROW = 412;
    localparam int LOGO_ORIGIN_COL = 530;
    localparam int LOGO_TILES      = 8;
    localparam int LOGO_TILE_PX    = 8;
    localparam int LOGO_WORDS      = 64;

    // Title text
    localparam int GLYPH_COLS  = 5;
    localparam int GLYPH_ROWS  = 7;
    localparam int GLYPH_SCALE = 2;
    localparam int CHAR_PITCH  = 14;
    localparam int LINE_PITCH  = 15;
    localparam int TEXT_LINES  = 5;
    localparam int LINE_CHARS  = 9;  // ADVENTURE

endpackage
